// ==== audipus_defs.svh ====
`ifndef AUDIPUS_DEFS_SVH
`define AUDIPUS_DEFS_SVH

// pcm word width, one channel
`define AUDIPUS_SAMPLE_W 16

// gain word is unsigned, 2 integer bits over 14 fraction bits
`define AUDIPUS_GAIN_W 16
`define AUDIPUS_GAIN_FRAC 14
// unity gain
`define AUDIPUS_GAIN_RESET 16'h4000

// half period of dac bit clock, in clk cycles
`define AUDIPUS_BCLK_DIV 4

// host register map
`define AUDIPUS_ADDR_CONTROL 7'h00
`define AUDIPUS_ADDR_GAIN_L_LSB 7'h01
`define AUDIPUS_ADDR_GAIN_L_MSB 7'h02
`define AUDIPUS_ADDR_GAIN_R_LSB 7'h03
`define AUDIPUS_ADDR_GAIN_R_MSB 7'h04
`define AUDIPUS_ADDR_STATUS 7'h05

`endif

// ==== audipus_pkg.sv ====
`include "audipus_defs.svh"

package audipus_pkg;

    //////////////////////////////////////////////////////////////////////
    // data words

    // one signed pcm sample
    typedef logic signed [`AUDIPUS_SAMPLE_W-1:0] pcm_sample_t;
    // one channel gain, unsigned fixed point
    typedef logic [`AUDIPUS_GAIN_W-1:0] gain_t;
    // host register value and address
    typedef logic [7:0] reg_byte_t;
    typedef logic [6:0] reg_addr_t;

    //////////////////////////////////////////////////////////////////////
    // state machines

    // spi slave, deselected / command byte / data byte
    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_ADDR,
        SPI_DATA
    } spi_state_t;

    // dac output, parked or framing
    typedef enum logic {
        TX_OFF,
        TX_RUN
    } tx_state_t;

endpackage

// ==== spi_reg_slave.sv ====
`include "audipus_defs.svh"

module spi_reg_slave
    import audipus_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  spi_cs_n,
    input  logic  spi_clk,
    input  logic  spi_mosi,
    output logic  spi_miso,
    input  logic  rx_valid,
    input  logic  clip_pulse,
    output logic  control_enable,
    output logic  control_mute,
    output gain_t gain_left,
    output gain_t gain_right
);

    localparam gain_t GAIN_RST = `AUDIPUS_GAIN_RESET;

    // pin synchronizers, extra stage on spi_clk for edges
    logic [1:0] cs_sync;
    logic [2:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic       cs_n_s;
    logic       mosi_s;
    logic       sclk_rise;
    logic       sclk_fall;

    spi_state_t state;
    // counts rising edges of the whole 16-bit transaction
    logic [4:0] bit_cnt;
    logic       rd_flag;
    reg_addr_t  addr;
    reg_byte_t  data_shift;
    reg_byte_t  miso_shift;
    reg_byte_t  rd_byte;
    logic       wr_stb;
    logic       data_edge;

    reg_byte_t  control_reg;
    reg_byte_t  gain_l_lsb;
    reg_byte_t  gain_r_lsb;
    logic       status_sample;
    logic       status_clip;
    logic [1:0] status_clr;

    always_ff @(posedge clk) begin
        if (rst) begin
            cs_sync   <= 2'b11;
            sclk_sync <= '0;
            mosi_sync <= '0;
        end else begin
            cs_sync   <= {cs_sync[0], spi_cs_n};
            sclk_sync <= {sclk_sync[1:0], spi_clk};
            mosi_sync <= {mosi_sync[0], spi_mosi};
        end
    end

    assign cs_n_s    = cs_sync[1];
    assign mosi_s    = mosi_sync[1];
    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
    // data byte still open, bits past the 16th are ignored
    assign data_edge = (state == SPI_DATA) && !bit_cnt[4];

    //////////////////////////////////////////////////////////////////////
    // transaction fsm

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= SPI_IDLE;
            bit_cnt <= '0;
            wr_stb  <= 1'b0;
        end else begin
            wr_stb <= 1'b0;
            if (cs_n_s) begin
                state   <= SPI_IDLE;
                bit_cnt <= '0;
            end else begin
                case (state)
                    SPI_IDLE: state <= SPI_ADDR;
                    SPI_ADDR: begin
                        if (sclk_rise) begin
                            bit_cnt <= bit_cnt + 5'd1;
                            if (bit_cnt == 5'd7) begin
                                state <= SPI_DATA;
                            end
                        end
                    end
                    default: begin
                        if (sclk_rise && data_edge) begin
                            bit_cnt <= bit_cnt + 5'd1;
                            // 16th edge, write lands next cycle
                            if (bit_cnt == 5'd15) begin
                                wr_stb <= ~rd_flag;
                            end
                        end
                    end
                endcase
            end
        end
    end

    // command bit ends up in rd_flag after eight shifts
    always_ff @(posedge clk) begin
        if (sclk_rise && state == SPI_ADDR) begin
            {rd_flag, addr} <= {addr, mosi_s};
        end
        if (sclk_rise && data_edge) begin
            data_shift <= {data_shift[6:0], mosi_s};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // readback on miso, changes on falling edges

    always_comb begin
        case (addr)
            `AUDIPUS_ADDR_CONTROL:    rd_byte = control_reg;
            `AUDIPUS_ADDR_GAIN_L_LSB: rd_byte = gain_l_lsb;
            `AUDIPUS_ADDR_GAIN_L_MSB: rd_byte = gain_left[15:8];
            `AUDIPUS_ADDR_GAIN_R_LSB: rd_byte = gain_r_lsb;
            `AUDIPUS_ADDR_GAIN_R_MSB: rd_byte = gain_right[15:8];
            `AUDIPUS_ADDR_STATUS:     rd_byte = {6'b0, status_clip, status_sample};
            default:                  rd_byte = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || cs_n_s) begin
            spi_miso <= 1'b0;
        end else if (sclk_fall && data_edge) begin
            // first fall after the command byte puts out the msb
            spi_miso <= (bit_cnt == 5'd8) ? rd_byte[7] : miso_shift[7];
        end
    end

    always_ff @(posedge clk) begin
        if (sclk_fall && data_edge) begin
            miso_shift <= (bit_cnt == 5'd8) ? {rd_byte[6:0], 1'b0} : {miso_shift[6:0], 1'b0};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // register file

    always_ff @(posedge clk) begin
        if (rst) begin
            control_reg <= '0;
            gain_l_lsb  <= GAIN_RST[7:0];
            gain_r_lsb  <= GAIN_RST[7:0];
            gain_left   <= GAIN_RST;
            gain_right  <= GAIN_RST;
        end else if (wr_stb) begin
            case (addr)
                `AUDIPUS_ADDR_CONTROL:    control_reg <= data_shift;
                // lsb staged, gain swaps in on the msb write
                `AUDIPUS_ADDR_GAIN_L_LSB: gain_l_lsb <= data_shift;
                `AUDIPUS_ADDR_GAIN_L_MSB: gain_left <= {data_shift, gain_l_lsb};
                `AUDIPUS_ADDR_GAIN_R_LSB: gain_r_lsb <= data_shift;
                `AUDIPUS_ADDR_GAIN_R_MSB: gain_right <= {data_shift, gain_r_lsb};
                default: ;
            endcase
        end
    end

    assign control_enable = control_reg[0];
    assign control_mute   = control_reg[1];

    // sticky flags, write 1 clears, a new event wins
    assign status_clr = (wr_stb && addr == `AUDIPUS_ADDR_STATUS) ? data_shift[1:0] : 2'b00;

    always_ff @(posedge clk) begin
        if (rst) begin
            status_sample <= 1'b0;
            status_clip   <= 1'b0;
        end else begin
            status_sample <= rx_valid | (status_sample & ~status_clr[0]);
            status_clip   <= clip_pulse | (status_clip & ~status_clr[1]);
        end
    end

    wr_in_data: assert property (@(posedge clk) disable iff (rst)
        wr_stb |-> $past(state) == SPI_DATA);

    // fsm idle means deselected, miso must be parked low
    miso_parked: assert property (@(posedge clk) disable iff (rst)
        state == SPI_IDLE |-> !spi_miso);

endmodule

// ==== i2s_receiver.sv ====
`include "audipus_defs.svh"

module i2s_receiver
    import audipus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        i2s_bclk,
    input  logic        i2s_lrclk,
    input  logic        i2s_d,
    output logic        rx_valid,
    output logic        rx_right,
    output pcm_sample_t rx_sample
);

    // two-flop synchronizers, third bclk flop for edge detect
    logic [2:0]  bclk_sync;
    logic [1:0]  lrclk_sync;
    logic [1:0]  d_sync;
    logic        bclk_rise;
    logic        lr_s;
    logic        lr_prev;
    logic        lr_change;
    // bits taken in this channel, parked at SAMPLE_W
    logic [4:0]  bit_cnt;
    logic        channel;
    pcm_sample_t shift;

    always_ff @(posedge clk) begin
        if (rst) begin
            bclk_sync  <= '0;
            lrclk_sync <= '0;
            d_sync     <= '0;
        end else begin
            bclk_sync  <= {bclk_sync[1:0], i2s_bclk};
            lrclk_sync <= {lrclk_sync[0], i2s_lrclk};
            d_sync     <= {d_sync[0], i2s_d};
        end
    end

    assign bclk_rise = bclk_sync[1] & ~bclk_sync[2];
    assign lr_s      = lrclk_sync[1];
    // word clock as seen on the previous bit
    assign lr_change = lr_s != lr_prev;

    //////////////////////////////////////////////////////////////////////
    // bit counter and channel tracking

    always_ff @(posedge clk) begin
        if (rst) begin
            lr_prev  <= 1'b0;
            bit_cnt  <= 5'(`AUDIPUS_SAMPLE_W);
            channel  <= 1'b0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (bclk_rise) begin
                lr_prev <= lr_s;
                if (lr_change) begin
                    // this bit still belongs to the old word
                    // msb comes on the next edge
                    bit_cnt <= '0;
                    channel <= lr_s;
                end else if (bit_cnt < 5'(`AUDIPUS_SAMPLE_W)) begin
                    bit_cnt <= bit_cnt + 5'd1;
                    if (bit_cnt == 5'(`AUDIPUS_SAMPLE_W - 1)) begin
                        rx_valid <= 1'b1;
                    end
                end
            end
        end
    end

    // msb first, extra bits past the word are dropped
    always_ff @(posedge clk) begin
        if (bclk_rise && !lr_change && bit_cnt < 5'(`AUDIPUS_SAMPLE_W)) begin
            shift <= {shift[`AUDIPUS_SAMPLE_W-2:0], d_sync[1]};
        end
    end

    assign rx_sample = shift;
    assign rx_right  = channel;

    valid_single: assert property (@(posedge clk) disable iff (rst)
        rx_valid |=> !rx_valid);

endmodule

// ==== gain_stage.sv ====
`include "audipus_defs.svh"

module gain_stage
    import audipus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        rx_valid,
    input  logic        rx_right,
    input  pcm_sample_t rx_sample,
    input  gain_t       gain_left,
    input  gain_t       gain_right,
    input  logic        control_mute,
    output logic        gain_valid,
    output logic        gain_right_out,
    output logic        clip_pulse,
    output pcm_sample_t gain_sample
);

    // signed sample times gain with a zero sign bit
    localparam int PROD_W   = `AUDIPUS_SAMPLE_W + `AUDIPUS_GAIN_W + 1;
    localparam int SCALED_W = PROD_W - `AUDIPUS_GAIN_FRAC;

    localparam pcm_sample_t PCM_MAX = {1'b0, {(`AUDIPUS_SAMPLE_W-1){1'b1}}};
    localparam pcm_sample_t PCM_MIN = {1'b1, {(`AUDIPUS_SAMPLE_W-1){1'b0}}};
    localparam logic signed [SCALED_W-1:0] SAT_MAX = PCM_MAX;
    localparam logic signed [SCALED_W-1:0] SAT_MIN = PCM_MIN;

    gain_t                      sel_gain;
    logic                       s1_valid;
    logic                       s1_right;
    logic signed [PROD_W-1:0]   s1_prod;
    logic signed [SCALED_W-1:0] scaled;
    logic                       over;
    logic                       under;

    //////////////////////////////////////////////////////////////////////
    // stage 1, channel gain and product

    assign sel_gain = rx_right ? gain_right : gain_left;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= rx_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_right <= rx_right;
        s1_prod  <= rx_sample * $signed({1'b0, sel_gain});
    end

    //////////////////////////////////////////////////////////////////////
    // stage 2, scale down, saturate, mute

    // dropping fraction bits of a two's complement value floors it
    assign scaled = s1_prod[PROD_W-1:`AUDIPUS_GAIN_FRAC];
    assign over   = scaled > SAT_MAX;
    assign under  = scaled < SAT_MIN;

    always_ff @(posedge clk) begin
        if (rst) begin
            gain_valid <= 1'b0;
            clip_pulse <= 1'b0;
        end else begin
            gain_valid <= s1_valid;
            // muted samples never count as clipped
            clip_pulse <= s1_valid && !control_mute && (over || under);
        end
    end

    always_ff @(posedge clk) begin
        gain_right_out <= s1_right;
        if (control_mute) begin
            gain_sample <= '0;
        end else if (over) begin
            gain_sample <= PCM_MAX;
        end else if (under) begin
            gain_sample <= PCM_MIN;
        end else begin
            gain_sample <= scaled[`AUDIPUS_SAMPLE_W-1:0];
        end
    end

    two_cycle_latency: assert property (@(posedge clk) disable iff (rst)
        gain_valid == $past(rx_valid, 2));

endmodule

// ==== i2s_transmitter.sv ====
`include "audipus_defs.svh"

module i2s_transmitter
    import audipus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        control_enable,
    input  logic        gain_valid,
    input  logic        gain_right,
    input  pcm_sample_t gain_sample,
    output logic        dac_rst,
    output logic        dac_bclk,
    output logic        dac_lrclk,
    output logic        dac_data
);

    localparam int DIV_W   = $clog2(`AUDIPUS_BCLK_DIV + 1);
    localparam int FRAME_W = 2 * `AUDIPUS_SAMPLE_W;
    localparam int SLOT_W  = $clog2(FRAME_W);

    tx_state_t           state;
    logic [DIV_W-1:0]    div_cnt;
    logic                div_wrap;
    logic                bclk_fall;
    // bit slot inside the frame, msb selects the channel
    logic [SLOT_W-1:0]   slot;
    logic [SLOT_W-1:0]   slot_next;
    pcm_sample_t         left_hold;
    pcm_sample_t         right_hold;
    logic [FRAME_W-1:0]  frame_shift;

    // latest sample of each channel
    always_ff @(posedge clk) begin
        if (rst) begin
            left_hold  <= '0;
            right_hold <= '0;
        end else if (gain_valid) begin
            if (gain_right) begin
                right_hold <= gain_sample;
            end else begin
                left_hold <= gain_sample;
            end
        end
    end

    assign div_wrap  = div_cnt == DIV_W'(`AUDIPUS_BCLK_DIV - 1);
    assign bclk_fall = div_wrap && dac_bclk;
    assign slot_next = slot + 1'b1;

    //////////////////////////////////////////////////////////////////////
    // clock divider and framing fsm

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= TX_OFF;
            dac_rst   <= 1'b1;
            dac_bclk  <= 1'b0;
            dac_lrclk <= 1'b0;
            dac_data  <= 1'b0;
            div_cnt   <= '0;
            slot      <= '0;
        end else if (state == TX_OFF || !control_enable) begin
            // parked, frame restarts at slot 0 on enable
            dac_rst   <= !control_enable;
            dac_bclk  <= 1'b0;
            dac_lrclk <= 1'b0;
            dac_data  <= 1'b0;
            div_cnt   <= '0;
            slot      <= '0;
            state     <= control_enable ? TX_RUN : TX_OFF;
        end else if (div_wrap) begin
            div_cnt  <= '0;
            dac_bclk <= ~dac_bclk;
            if (dac_bclk) begin
                // data trails the word clock by one bit
                slot      <= slot_next;
                dac_lrclk <= slot_next[SLOT_W-1];
                dac_data  <= frame_shift[FRAME_W-1];
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // pair is loaded at frame start, left word in the upper half
    always_ff @(posedge clk) begin
        if (state == TX_OFF) begin
            frame_shift <= {left_hold, right_hold};
        end else if (bclk_fall) begin
            if (slot_next == '0) begin
                frame_shift <= {left_hold, right_hold};
            end else begin
                frame_shift <= frame_shift << 1;
            end
        end
    end

    dac_parked: assert property (@(posedge clk) disable iff (rst)
        !control_enable |=> (state == TX_OFF && dac_rst && !dac_bclk && !dac_lrclk));

endmodule

// ==== audipus_core.sv ====
module audipus_core
    import audipus_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic spi_cs_n,
    input  logic spi_clk,
    input  logic spi_mosi,
    input  logic i2s_bclk,
    input  logic i2s_lrclk,
    input  logic i2s_d,
    output logic spi_miso,
    output logic dac_rst,
    output logic dac_bclk,
    output logic dac_lrclk,
    output logic dac_data
);

    // host controls
    logic        control_enable;
    logic        control_mute;
    gain_t       gain_left;
    gain_t       gain_right;
    // receiver to gain stage
    logic        rx_valid;
    logic        rx_right;
    pcm_sample_t rx_sample;
    // gain stage to transmitter
    logic        gain_valid;
    logic        out_right;
    logic        clip_pulse;
    pcm_sample_t gain_sample;

    //////////////////////////////////////////////////////////////////////
    // host side

    spi_reg_slave spi_reg_slave0 (
        .clk            (clk),
        .rst            (rst),
        .spi_cs_n       (spi_cs_n),
        .spi_clk        (spi_clk),
        .spi_mosi       (spi_mosi),
        .spi_miso       (spi_miso),
        .rx_valid       (rx_valid),
        .clip_pulse     (clip_pulse),
        .control_enable (control_enable),
        .control_mute   (control_mute),
        .gain_left      (gain_left),
        .gain_right     (gain_right)
    );

    //////////////////////////////////////////////////////////////////////
    // audio path, i2s in, gain, i2s out to dac

    i2s_receiver i2s_receiver0 (
        .clk       (clk),
        .rst       (rst),
        .i2s_bclk  (i2s_bclk),
        .i2s_lrclk (i2s_lrclk),
        .i2s_d     (i2s_d),
        .rx_valid  (rx_valid),
        .rx_right  (rx_right),
        .rx_sample (rx_sample)
    );

    gain_stage gain_stage0 (
        .clk            (clk),
        .rst            (rst),
        .rx_valid       (rx_valid),
        .rx_right       (rx_right),
        .rx_sample      (rx_sample),
        .gain_left      (gain_left),
        .gain_right     (gain_right),
        .control_mute   (control_mute),
        .gain_valid     (gain_valid),
        .gain_right_out (out_right),
        .clip_pulse     (clip_pulse),
        .gain_sample    (gain_sample)
    );

    i2s_transmitter i2s_transmitter0 (
        .clk            (clk),
        .rst            (rst),
        .control_enable (control_enable),
        .gain_valid     (gain_valid),
        .gain_right     (out_right),
        .gain_sample    (gain_sample),
        .dac_rst        (dac_rst),
        .dac_bclk       (dac_bclk),
        .dac_lrclk      (dac_lrclk),
        .dac_data       (dac_data)
    );

endmodule

// ==== audipus_tb.sv ====
`include "audipus_defs.svh"

module audipus_tb
    import audipus_pkg::*;
();

    localparam int DRIVE_DLY       = 2;
    localparam int SPI_HALF        = 4;
    localparam int SRC_SLOTS       = 64;
    localparam int DAC_FRAME_CLKS  = 64 * `AUDIPUS_BCLK_DIV;
    localparam int WATCHDOG_CYCLES = 120000;
    localparam gain_t GAIN_UNITY   = `AUDIPUS_GAIN_RESET;

    logic clk;
    logic rst;
    logic spi_cs_n;
    logic spi_clk;
    logic spi_mosi;
    logic i2s_bclk;
    logic i2s_lrclk;
    logic i2s_d;
    logic spi_miso;
    logic dac_rst;
    logic dac_bclk;
    logic dac_lrclk;
    logic dac_data;

    string       test_name = "startup";
    logic [15:0] lfsr_state = 16'd37307;
    logic        expect_parked = 1'b1;
    reg_byte_t   reg_model [0:5];

    // i2s source control, pair is latched at each frame start
    logic        src_run = 1'b0;
    logic        src_idle = 1'b1;
    int          src_frames = 0;
    pcm_sample_t tx_left = '0;
    pcm_sample_t tx_right = '0;

    // current host settings, for the expected words
    gain_t       gain_l_cur = GAIN_UNITY;
    gain_t       gain_r_cur = GAIN_UNITY;
    logic        mute_cur = 1'b0;

    // dac decoder state
    logic        bclk_prev;
    logic        lr_prev;
    int          bit_count;
    logic        have_left;
    logic [14:0] shift_in;
    pcm_sample_t dec_left;
    pcm_sample_t dec_right;
    int          dec_frames = 0;

    audipus_core dut0 (
        .clk       (clk),
        .rst       (rst),
        .spi_cs_n  (spi_cs_n),
        .spi_clk   (spi_clk),
        .spi_mosi  (spi_mosi),
        .i2s_bclk  (i2s_bclk),
        .i2s_lrclk (i2s_lrclk),
        .i2s_d     (i2s_d),
        .spi_miso  (spi_miso),
        .dac_rst   (dac_rst),
        .dac_bclk  (dac_bclk),
        .dac_lrclk (dac_lrclk),
        .dac_data  (dac_data)
    );

    always #20 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // failure reporting

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic report_mismatch(input logic [15:0] exp, input logic [15:0] act);
        $display("error: %s expected 0x%04h actual 0x%04h", test_name, exp, act);
        abort_run();
    endtask

    task automatic report_failure(input string what);
        $display("%s, during test %s", what, test_name);
        abort_run();
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[14:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return val;
    endfunction

    // floor(sample * gain / 2^14), saturated, zero when muted
    function automatic pcm_sample_t expected_gain_output(input pcm_sample_t s, input gain_t g,
                                                         input logic mute);
        longint prod;
        longint scaled;
        prod   = longint'(s) * longint'({1'b0, g});
        scaled = prod >>> `AUDIPUS_GAIN_FRAC;
        if (mute) begin
            return '0;
        end
        if (scaled > 32767) begin
            return 16'sh7FFF;
        end
        if (scaled < -32768) begin
            return 16'sh8000;
        end
        return pcm_sample_t'(scaled);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // spi host, mode 0, 8 clk per spi_clk period

    task automatic spi_xfer(input logic [15:0] word, output reg_byte_t rdata);
        rdata = '0;
        @(posedge clk);
        #DRIVE_DLY;
        spi_cs_n = 1'b0;
        for (int i = 15; i >= 0; i--) begin
            spi_mosi = word[i];
            repeat (SPI_HALF) @(posedge clk);
            #DRIVE_DLY;
            // miso settled since the last falling edge
            if (i < 8) begin
                rdata = {rdata[6:0], spi_miso};
            end
            spi_clk = 1'b1;
            repeat (SPI_HALF) @(posedge clk);
            #DRIVE_DLY;
            spi_clk = 1'b0;
        end
        repeat (SPI_HALF) @(posedge clk);
        #DRIVE_DLY;
        spi_cs_n = 1'b1;
        spi_mosi = 1'b0;
        repeat (SPI_HALF) @(posedge clk);
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_byte_t data);
        reg_byte_t unused;
        spi_xfer({1'b0, addr, data}, unused);
    endtask

    task automatic check_reg(input reg_addr_t addr, input reg_byte_t exp);
        reg_byte_t got;
        spi_xfer({1'b1, addr, 8'h00}, got);
        reg_value: assert (got == exp) else report_mismatch(exp, got);
    endtask

    task automatic check_all_regs();
        for (int a = 0; a < 6; a++) begin
            check_reg(reg_addr_t'(a), reg_model[a]);
        end
    endtask

    // lsb staged first, msb write makes the gain live
    task automatic set_gains(input gain_t gl, input gain_t gr);
        write_reg(`AUDIPUS_ADDR_GAIN_L_LSB, gl[7:0]);
        write_reg(`AUDIPUS_ADDR_GAIN_L_MSB, gl[15:8]);
        write_reg(`AUDIPUS_ADDR_GAIN_R_LSB, gr[7:0]);
        write_reg(`AUDIPUS_ADDR_GAIN_R_MSB, gr[15:8]);
        gain_l_cur = gl;
        gain_r_cur = gr;
    endtask

    //////////////////////////////////////////////////////////////////////
    // i2s source, philips format, 32-bit slot per channel

    task automatic i2s_slot(input logic lr, input logic d);
        @(posedge clk);
        #DRIVE_DLY;
        i2s_bclk  = 1'b0;
        i2s_lrclk = lr;
        i2s_d     = d;
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        i2s_bclk = 1'b1;
        repeat (2) @(posedge clk);
    endtask

    // msb one slot after the word clock change, zero padded
    function automatic logic source_bit(input pcm_sample_t l, input pcm_sample_t r,
                                        input int slot);
        int pos;
        pos = slot % 32;
        if (pos < 1 || pos > 16) begin
            return 1'b0;
        end
        return (slot < 32) ? l[16-pos] : r[16-pos];
    endfunction

    initial begin : i2s_source
        pcm_sample_t frame_l;
        pcm_sample_t frame_r;
        forever begin
            if (!src_run) begin
                src_idle = 1'b1;
                @(posedge clk);
            end else begin
                src_idle = 1'b0;
                frame_l  = tx_left;
                frame_r  = tx_right;
                for (int slot = 0; slot < SRC_SLOTS; slot++) begin
                    i2s_slot(slot >= 32, source_bit(frame_l, frame_r, slot));
                end
                src_frames++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // dac decoder, bits taken on rising dac_bclk

    always @(posedge clk) begin
        if (rst || dac_rst) begin
            bclk_prev <= 1'b0;
            lr_prev   <= 1'b0;
            bit_count <= 0;
            have_left <= 1'b0;
        end else begin
            bclk_prev <= dac_bclk;
            if (dac_bclk && !bclk_prev) begin
                shift_in <= {shift_in[13:0], dac_data};
                lr_prev  <= dac_lrclk;
                if (dac_lrclk != lr_prev) begin
                    // lsb of the word that just ended
                    bit_count <= 0;
                    if (bit_count >= 15 && lr_prev) begin
                        dec_right  <= {shift_in, dac_data};
                        dec_frames <= dec_frames + (have_left ? 1 : 0);
                        have_left  <= 1'b0;
                    end else if (bit_count >= 15) begin
                        dec_left  <= {shift_in, dac_data};
                        have_left <= 1'b1;
                    end
                end else if (bit_count < 16) begin
                    bit_count <= bit_count + 1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // waits, each bounded

    task automatic wait_src_frames(input int n);
        int target;
        int budget;
        target = src_frames + n;
        budget = (n + 1) * SRC_SLOTS * 6 + 200;
        while (src_frames < target) begin
            @(posedge clk);
            #DRIVE_DLY;
            budget--;
            if (budget == 0) begin
                report_failure("timed out waiting for the i2s source to finish frames");
            end
        end
    endtask

    task automatic wait_dec_frames(input int n);
        int target;
        int budget;
        target = dec_frames + n;
        budget = (n + 1) * DAC_FRAME_CLKS + 200;
        while (dec_frames < target) begin
            @(posedge clk);
            #DRIVE_DLY;
            budget--;
            if (budget == 0) begin
                report_failure("timed out waiting for a decoded dac frame");
            end
        end
    endtask

    task automatic stop_source();
        int budget;
        budget = 2 * SRC_SLOTS * 6;
        src_run = 1'b0;
        while (!src_idle) begin
            @(posedge clk);
            #DRIVE_DLY;
            budget--;
            if (budget == 0) begin
                report_failure("i2s source did not go idle");
            end
        end
    endtask

    // let the new pair and gains reach the dac, then compare frames
    task automatic check_output(input pcm_sample_t exp_l, input pcm_sample_t exp_r);
        wait_src_frames(2);
        wait_dec_frames(3);
        repeat (2) begin
            wait_dec_frames(1);
            left_word: assert (dec_left == exp_l) else report_mismatch(exp_l, dec_left);
            right_word: assert (dec_right == exp_r) else report_mismatch(exp_r, dec_right);
        end
    endtask

    task automatic check_scaled();
        check_output(expected_gain_output(tx_left, gain_l_cur, mute_cur),
                     expected_gain_output(tx_right, gain_r_cur, mute_cur));
    endtask

    //////////////////////////////////////////////////////////////////////
    // always-on checks

    dac_parked_check: assert property (@(posedge clk) disable iff (rst)
        expect_parked |-> (dac_rst && !dac_bclk && !dac_lrclk && !dac_data))
        else report_failure("dac clocks or data moved while output was disabled");

    miso_idle_check: assert property (@(posedge clk) disable iff (rst)
        (spi_cs_n && $past(spi_cs_n, 4)) |-> !spi_miso)
        else report_failure("spi_miso was driven high while the slave was deselected");

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure("simulation ran past its cycle budget");
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        spi_cs_n  = 1'b1;
        spi_clk   = 1'b0;
        spi_mosi  = 1'b0;
        i2s_bclk  = 1'b0;
        i2s_lrclk = 1'b0;
        i2s_d     = 1'b0;
        repeat (10) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        repeat (4) @(posedge clk);

        test_name    = "reset_values";
        reg_model[0] = 8'h00;
        reg_model[1] = GAIN_UNITY[7:0];
        reg_model[2] = GAIN_UNITY[15:8];
        reg_model[3] = GAIN_UNITY[7:0];
        reg_model[4] = GAIN_UNITY[15:8];
        reg_model[5] = 8'h00;
        check_all_regs();
        dac_held: assert (dac_rst == 1'b1) else report_mismatch(16'd1, 16'(dac_rst));

        test_name = "register_access";
        // enable kept off, dac stays parked
        reg_model[0] = rand_bits(8) & 8'hFE;
        write_reg(`AUDIPUS_ADDR_CONTROL, reg_model[0]);
        for (int a = 1; a < 5; a++) begin
            reg_model[a] = rand_bits(8);
            write_reg(reg_addr_t'(a), reg_model[a]);
        end
        check_all_regs();
        write_reg(7'h06, rand_bits(8));
        write_reg(7'h3C, rand_bits(8));
        check_all_regs();
        check_reg(7'h06, 8'h00);
        check_reg(7'h3C, 8'h00);
        write_reg(`AUDIPUS_ADDR_CONTROL, 8'h00);
        set_gains(GAIN_UNITY, GAIN_UNITY);

        test_name     = "unity_passthrough";
        expect_parked = 1'b0;
        write_reg(`AUDIPUS_ADDR_CONTROL, 8'h01);
        tx_left  = rand_bits(16);
        tx_right = rand_bits(16);
        src_run  = 1'b1;
        check_output(tx_left, tx_right);
        check_reg(`AUDIPUS_ADDR_STATUS, 8'h01);

        test_name = "gain_and_clip";
        set_gains(16'h2000, 16'h6000);
        tx_left  = rand_bits(16);
        tx_right = rand_bits(16);
        check_scaled();
        set_gains(rand_bits(16), rand_bits(16));
        tx_left  = rand_bits(16);
        tx_right = rand_bits(16);
        check_scaled();
        // twice full scale, both rails
        set_gains(16'h8000, 16'h8000);
        tx_left  = 16'sh7FFF;
        tx_right = 16'sh8000;
        check_output(16'sh7FFF, 16'sh8000);
        check_reg(`AUDIPUS_ADDR_STATUS, 8'h03);
        stop_source();
        write_reg(`AUDIPUS_ADDR_STATUS, 8'h03);
        check_reg(`AUDIPUS_ADDR_STATUS, 8'h00);

        test_name = "mute_and_disable";
        mute_cur  = 1'b1;
        write_reg(`AUDIPUS_ADDR_CONTROL, 8'h03);
        src_run = 1'b1;
        check_scaled();
        check_reg(`AUDIPUS_ADDR_STATUS, 8'h01);
        write_reg(`AUDIPUS_ADDR_CONTROL, 8'h00);
        expect_parked = 1'b1;
        repeat (4 * DAC_FRAME_CLKS) @(posedge clk);
        #DRIVE_DLY;
        dac_off: assert (dac_rst == 1'b1) else report_mismatch(16'd1, 16'(dac_rst));

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== audipus.f ====
+incdir+.
audipus_pkg.sv
spi_reg_slave.sv
i2s_receiver.sv
gain_stage.sv
i2s_transmitter.sv
audipus_core.sv
audipus_tb.sv

// ==== Bender.yml ====
package:
  name: audipus

export_include_dirs:
  - .

sources:
  - files:
      - audipus_pkg.sv
      - spi_reg_slave.sv
      - i2s_receiver.sv
      - gain_stage.sv
      - i2s_transmitter.sv
      - audipus_core.sv
  - target: test
    files:
      - audipus_tb.sv
